//--- include/datapath_consts.svh
// sizes and reset values shared by the datapath RTL, pulled in with `include
`ifndef DATAPATH_CONSTS_SVH
`define DATAPATH_CONSTS_SVH

// width of the internal bus and of every register
`define WORD_WIDTH 32

// general purpose registers R0..R15
`define NUM_REGS 16

// shifts and rotates use this many low bits of operand B
`define SHAMT_WIDTH 5

// PC value after reset
`define PC_RESET 32'h0000_0000

`endif

//--- hw/datapath_pkg.sv
// datapath types shared by the bus peers, the arbiter and the top level
`default_nettype none

`include "datapath_consts.svh"

package datapath_pkg;

	// one strobe per bus driver
	typedef struct packed {
		logic pcOut;
		logic mdrOut;
		logic zHighOut;
		logic zLowOut;
		logic cOut;
		logic [`NUM_REGS-1:0] regOut; // bit i puts Ri on the bus
	} busSrcT;

	// register load strobes, sampled on the rising edge
	typedef struct packed {
		logic marIn;
		logic mdrIn;
		logic pcIn;
		logic irIn;
		logic yIn;
		logic zIn;
		logic [`NUM_REGS-1:0] regIn;
	} loadEnT;

	typedef enum logic [3:0] {
		add   = 4'd0,
		sub   = 4'd1,
		andOp = 4'd2,
		orOp  = 4'd3,
		shl   = 4'd4,
		shr   = 4'd5,
		shra  = 4'd6,
		rol   = 4'd7,
		ror   = 4'd8,
		neg   = 4'd9,
		notOp = 4'd10,
		mul   = 4'd11,
		div   = 4'd12,
		incPc = 4'd13
	} aluOpT;

	// register format: three register fields
	typedef struct packed {
		logic [4:0] opcode;
		logic [3:0] ra;
		logic [3:0] rb;
		logic [3:0] rc;
		logic [14:0] unused;
	} regFmtT;

	// immediate format: two registers and a signed constant
	typedef struct packed {
		logic [4:0] opcode;
		logic [3:0] ra;
		logic [3:0] rb;
		logic signed [18:0] imm;
	} immFmtT;

	typedef union packed {
		regFmtT r;
		immFmtT i;
	} instrT;

	// Z is 64 bits so mul and div can return two words
	typedef struct packed {
		logic [`WORD_WIDTH-1:0] high;
		logic [`WORD_WIDTH-1:0] low;
	} zPairT;

endpackage

`default_nettype wire

//--- hw/busArbiter.sv
// picks the single driver of the internal bus by fixed priority and flags multiple drivers
`timescale 1ns/1ps
`default_nettype none

`include "datapath_consts.svh"

module busArbiter (
	input  datapath_pkg::busSrcT                     busSrc,
	input  logic [`NUM_REGS-1:0][`WORD_WIDTH-1:0]    regData,
	input  logic [`WORD_WIDTH-1:0]                   mdrData,
	input  logic [`WORD_WIDTH-1:0]                   pcData,
	input  logic [`WORD_WIDTH-1:0]                   cData,
	input  datapath_pkg::zPairT                      zPair,
	output logic [`WORD_WIDTH-1:0]                   busData,
	output logic                                     busConflict
);

	localparam int numSrc = $bits(busSrc);

	logic [$clog2(numSrc+1)-1:0] srcCount; // number of asserted strobes

	// zLow first, registers last with R0 winning among them
	always_comb begin
		busData = '0;
		if (busSrc.zLowOut) busData = zPair.low;
		else if (busSrc.zHighOut) busData = zPair.high;
		else if (busSrc.mdrOut) busData = mdrData;
		else if (busSrc.pcOut) busData = pcData;
		else if (busSrc.cOut) busData = cData;
		else begin
			// walk down so the lowest index is the last one written
			for (int i = `NUM_REGS-1; i >= 0; i--) begin
				if (busSrc.regOut[i]) busData = regData[i];
			end
		end
	end

	always_comb begin
		srcCount = '0;
		for (int i = 0; i < numSrc; i++) begin
			srcCount = srcCount + busSrc[i];
		end
	end

	assign busConflict = (srcCount > 1);

endmodule

`default_nettype wire

//--- hw/registerFile.sv
// general register file, written from the bus and read out to the arbiter as a flat bank
`timescale 1ns/1ps
`default_nettype none

`include "datapath_consts.svh"

module registerFile (
	input  logic                                  Clock,
	input  logic                                  rstN,
	input  logic [`NUM_REGS-1:0]                  regIn,   // one bit per register
	input  logic [`WORD_WIDTH-1:0]                busData,
	output logic [`NUM_REGS-1:0][`WORD_WIDTH-1:0] regData
);

	// every register sits on the arbiter side, the arbiter
	// decides which one reaches the bus

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			regData <= '0;
		end else begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				if (regIn[i]) regData[i] <= busData; // several may load the same word
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/memInterface.sv
// MAR and MDR between the internal bus and external memory
`timescale 1ns/1ps
`default_nettype none

`include "datapath_consts.svh"

module memInterface (
	input  logic                   Clock,
	input  logic                   rstN,
	input  logic                   marIn,
	input  logic                   mdrIn,
	input  logic                   read,
	input  logic [`WORD_WIDTH-1:0] memData,
	input  logic [`WORD_WIDTH-1:0] busData,
	output logic [`WORD_WIDTH-1:0] marAddr,
	output logic [`WORD_WIDTH-1:0] mdrData
);

	logic [`WORD_WIDTH-1:0] mdrNext;

	// read selects the memory side of the MDR input mux
	assign mdrNext = read ? memData : busData;

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			marAddr <= '0;
			mdrData <= '0;
		end else begin
			if (marIn) marAddr <= busData;
			if (mdrIn) mdrData <= mdrNext;
		end
	end

endmodule

`default_nettype wire

//--- hw/fetchRegs.sv
// program counter and instruction register, with the sign-extended immediate for cOut
`timescale 1ns/1ps
`default_nettype none

`include "datapath_consts.svh"

module fetchRegs (
	input  logic                   Clock,
	input  logic                   rstN,
	input  logic                   pcIn,
	input  logic                   irIn,
	input  logic [`WORD_WIDTH-1:0] busData,
	output logic [`WORD_WIDTH-1:0] pcData,
	output logic [`WORD_WIDTH-1:0] cData
);

	import datapath_pkg::*;

	instrT ir;

	localparam int immWidth = $bits(ir.i.imm);

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			pcData <= `PC_RESET;
			ir     <= '0;
		end else begin
			if (pcIn) pcData <= busData;
			if (irIn) ir     <= busData;
		end
	end

	// immediate view of the IR, constant extended to a full word
	assign cData = {{(`WORD_WIDTH-immWidth){ir.i.imm[immWidth-1]}}, ir.i.imm};

endmodule

`default_nettype wire

//--- hw/alu.sv
// Y operand register, the ALU and the 64-bit Z result register
`timescale 1ns/1ps
`default_nettype none

`include "datapath_consts.svh"

module alu (
	input  logic                   Clock,
	input  logic                   rstN,
	input  logic                   yIn,
	input  logic                   zIn,
	input  datapath_pkg::aluOpT    aluOp,
	input  logic [`WORD_WIDTH-1:0] busData,
	output datapath_pkg::zPairT    zPair
);

	import datapath_pkg::*;

	logic [`WORD_WIDTH-1:0]          yReg;     // operand A
	logic [`SHAMT_WIDTH-1:0]         shamt;
	logic signed [2*`WORD_WIDTH-1:0] product;
	logic [`WORD_WIDTH-1:0]          quotient;
	logic [`WORD_WIDTH-1:0]          remainder;
	zPairT                           zNext;

	assign shamt   = busData[`SHAMT_WIDTH-1:0];
	assign product = $signed(yReg) * $signed(busData);

	// divide by zero leaves quotient zero and remainder A
	always_comb begin
		if (busData == '0) begin
			quotient  = '0;
			remainder = yReg;
		end else begin
			quotient  = $signed(yReg) / $signed(busData);
			remainder = $signed(yReg) % $signed(busData);
		end
	end

	always_comb begin
		zNext = '0; // single-word results leave high at zero
		case (aluOp)
			add:   zNext.low = yReg + busData;
			sub:   zNext.low = yReg - busData;
			andOp: zNext.low = yReg & busData;
			orOp:  zNext.low = yReg | busData;
			shl:   zNext.low = yReg << shamt;
			shr:   zNext.low = yReg >> shamt;
			shra:  zNext.low = $signed(yReg) >>> shamt;
			rol:   zNext.low = (yReg << shamt) | (yReg >> (`WORD_WIDTH - shamt));
			ror:   zNext.low = (yReg >> shamt) | (yReg << (`WORD_WIDTH - shamt));
			neg:   zNext.low = -busData;   // unary ops take the bus operand
			notOp: zNext.low = ~busData;
			mul:   zNext = product;
			div: begin
				zNext.high = remainder;
				zNext.low  = quotient;
			end
			incPc: zNext.low = busData + 1'b1;
			default: zNext = '0;
		endcase
	end

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			yReg  <= '0;
			zPair <= '0;
		end else begin
			if (yIn) yReg  <= busData;
			if (zIn) zPair <= zNext;
		end
	end

endmodule

`default_nettype wire

//--- hw/cpuDatapath.sv
// single-bus datapath top, strobed each cycle by an outside control unit
`timescale 1ns/1ps
`default_nettype none

`include "datapath_consts.svh"

module cpuDatapath (
	input  logic                   Clock,
	input  logic                   rstN,
	input  datapath_pkg::busSrcT   busSrc,
	input  datapath_pkg::loadEnT   loadEn,
	input  logic                   read,
	input  logic [`WORD_WIDTH-1:0] memData,
	input  datapath_pkg::aluOpT    aluOp,
	output logic [`WORD_WIDTH-1:0] marAddr,
	output logic [`WORD_WIDTH-1:0] mdrData,
	output logic [`WORD_WIDTH-1:0] busData,
	output logic                   busConflict
);

	import datapath_pkg::*;

	// candidate words offered to the arbiter
	logic [`NUM_REGS-1:0][`WORD_WIDTH-1:0] regData;
	logic [`WORD_WIDTH-1:0]                pcData;
	logic [`WORD_WIDTH-1:0]                cData;
	zPairT                                 zPair;

	busArbiter arbiter (
		.busSrc(busSrc), .regData(regData), .mdrData(mdrData), .pcData(pcData),
		.cData(cData), .zPair(zPair), .busData(busData), .busConflict(busConflict)
	);

	registerFile regFile (
		.Clock(Clock), .rstN(rstN), .regIn(loadEn.regIn), .busData(busData),
		.regData(regData)
	);

	memInterface memIf (
		.Clock(Clock), .rstN(rstN), .marIn(loadEn.marIn), .mdrIn(loadEn.mdrIn),
		.read(read), .memData(memData), .busData(busData),
		.marAddr(marAddr), .mdrData(mdrData)
	);

	fetchRegs fetch (
		.Clock(Clock), .rstN(rstN), .pcIn(loadEn.pcIn), .irIn(loadEn.irIn),
		.busData(busData), .pcData(pcData), .cData(cData)
	);

	alu aluUnit (
		.Clock(Clock), .rstN(rstN), .yIn(loadEn.yIn), .zIn(loadEn.zIn),
		.aluOp(aluOp), .busData(busData), .zPair(zPair)
	);

endmodule

`default_nettype wire

//--- tests/datapath_tb.sv
// directed testbench for cpuDatapath, acting as control unit and memory; top module datapath_tb
`timescale 1ns/1ps
`default_nettype none

`include "datapath_consts.svh"

module datapath_tb;

	import datapath_pkg::*;

	localparam int waitLimit = 16; // cycles before a wait gives up

	logic                   Clock;
	logic                   rstN;
	busSrcT                 busSrc;
	loadEnT                 loadEn;
	logic                   read;
	logic [`WORD_WIDTH-1:0] memData;
	aluOpT                  aluOp;
	logic [`WORD_WIDTH-1:0] marAddr;
	logic [`WORD_WIDTH-1:0] mdrData;
	logic [`WORD_WIDTH-1:0] busData;
	logic                   busConflict;
	integer                 seed;

	cpuDatapath i_dut (
		.Clock(Clock), .rstN(rstN), .busSrc(busSrc), .loadEn(loadEn), .read(read),
		.memData(memData), .aluOp(aluOp), .marAddr(marAddr), .mdrData(mdrData),
		.busData(busData), .busConflict(busConflict)
	);

	initial begin
		Clock = 1'b0;
		forever #10 Clock = ~Clock;
	end

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic checkWord(input string testName, input logic [`WORD_WIDTH-1:0] expected,
			input logic [`WORD_WIDTH-1:0] actual);
		assert (actual === expected) else
			abortRun($sformatf("FAIL %s: expected %h, actual %h", testName, expected, actual));
	endtask

	// old strobes load at this edge and the ones set after return act in the coming cycle
	task automatic nextCycle();
		@(posedge Clock);
		busSrc <= '0;
		loadEn <= '0;
		read   <= 1'b0;
	endtask

	task automatic sampleBus(output logic [`WORD_WIDTH-1:0] value);
		@(negedge Clock); // bus has settled mid cycle
		value = busData;
	endtask

	// memory word into MDR, then MDR into register idx
	task automatic loadReg(input int idx, input logic [`WORD_WIDTH-1:0] word);
		int n;
		nextCycle();
		read         <= 1'b1;
		memData      <= word;
		loadEn.mdrIn <= 1'b1;
		n = 0;
		do begin
			@(negedge Clock);
			n++;
			if (n > waitLimit) abortRun("MDR did not take the memory word in time");
		end while (mdrData !== word);
		nextCycle();
		busSrc.mdrOut     <= 1'b1;
		loadEn.regIn[idx] <= 1'b1;
		nextCycle();
	endtask

	task automatic readReg(input int idx, output logic [`WORD_WIDTH-1:0] value);
		nextCycle();
		busSrc.regOut[idx] <= 1'b1;
		sampleBus(value);
	endtask

	// Y from ra, op applied with rb, then Z low to R5 and Z high to R6
	task automatic applyOp(input aluOpT op, input int ra, input int rb);
		nextCycle();
		busSrc.regOut[ra] <= 1'b1;
		loadEn.yIn        <= 1'b1;
		nextCycle();
		busSrc.regOut[rb] <= 1'b1;
		loadEn.zIn        <= 1'b1;
		aluOp             <= op;
		nextCycle();
		busSrc.zLowOut  <= 1'b1;
		loadEn.regIn[5] <= 1'b1;
		nextCycle();
		busSrc.zHighOut <= 1'b1;
		loadEn.regIn[6] <= 1'b1; // loads on the next readReg edge
	endtask

	function automatic logic [`WORD_WIDTH-1:0] expectLow(input aluOpT op,
			input logic [`WORD_WIDTH-1:0] a, input logic [`WORD_WIDTH-1:0] b);
		logic [2*`WORD_WIDTH-1:0] twice;
		int s;
		twice = {a, a};
		s = b % 32;
		case (op)
			add:     return a + b;
			sub:     return a - b;
			andOp:   return a & b;
			orOp:    return a | b;
			shl:     return a << s;
			shr:     return a >> s;
			shra:    return (a >> s) | (a[31] ? ~(32'hffff_ffff >> s) : 32'h0);
			rol:     return twice[63-s -: 32]; // window into the doubled word
			ror:     return twice[31+s -: 32];
			neg:     return 32'h0 - b;
			notOp:   return ~b;
			default: return 'x;
		endcase
	endfunction

	task automatic resetTest();
		logic [`WORD_WIDTH-1:0] v;
		for (int i = 0; i < `NUM_REGS; i++) begin
			readReg(i, v);
			checkWord("reset register", 0, v);
			checkWord("reset conflict", 0, busConflict);
		end
		checkWord("reset MAR", 0, marAddr);
	endtask

	task automatic memTest();
		logic [`WORD_WIDTH-1:0] words [1:3];
		logic [`WORD_WIDTH-1:0] v;
		for (int i = 1; i <= 3; i++) begin
			words[i] = $random(seed);
			loadReg(i, words[i]);
		end
		for (int i = 1; i <= 3; i++) begin
			readReg(i, v);
			checkWord("memory load", words[i], v);
		end
		nextCycle();
		busSrc.regOut[2] <= 1'b1; // read is low so MDR takes the bus
		loadEn.mdrIn     <= 1'b1;
		loadEn.marIn     <= 1'b1;
		readReg(3, v);
		checkWord("MDR from bus", words[2], mdrData);
		checkWord("MAR load", words[2], marAddr);
	endtask

	task automatic aluTest();
		logic [`WORD_WIDTH-1:0] a;
		logic [`WORD_WIDTH-1:0] b;
		logic [`WORD_WIDTH-1:0] v;
		aluOpT op;
		for (int k = add; k <= notOp; k++) begin
			op = aluOpT'(k);
			a = $random(seed);
			b = $random(seed);
			loadReg(2, a);
			loadReg(4, b);
			applyOp(op, 2, 4);
			readReg(5, v);
			checkWord({op.name(), " low"}, expectLow(op, a, b), v);
			readReg(6, v);
			checkWord({op.name(), " high"}, 0, v);
		end
	endtask

	task automatic mulDivTest();
		logic signed [`WORD_WIDTH-1:0] a;
		logic signed [`WORD_WIDTH-1:0] b;
		logic signed [2*`WORD_WIDTH-1:0] wide;
		logic [`WORD_WIDTH-1:0] v;
		a = $random(seed);
		b = $random(seed);
		if (b == 0) b = 3;
		wide = a;
		wide = wide * b; // b extends by sign as both are signed
		loadReg(2, a);
		loadReg(4, b);
		applyOp(mul, 2, 4);
		readReg(5, v);
		checkWord("mul low", wide[31:0], v);
		readReg(6, v);
		checkWord("mul high", wide[63:32], v);
		applyOp(div, 2, 4);
		readReg(5, v);
		checkWord("div quotient", a / b, v);
		readReg(6, v);
		checkWord("div remainder", a % b, v);
	endtask

	task automatic fetchTest();
		logic [`WORD_WIDTH-1:0] v;
		instrT word;
		logic [18:0] imm;
		nextCycle(); // PC to MAR, PC plus one into Z
		busSrc.pcOut <= 1'b1;
		loadEn.marIn <= 1'b1;
		loadEn.zIn   <= 1'b1;
		aluOp        <= incPc;
		nextCycle();
		busSrc.zLowOut <= 1'b1;
		loadEn.pcIn    <= 1'b1;
		nextCycle();
		busSrc.pcOut <= 1'b1;
		sampleBus(v);
		checkWord("fetch MAR", `PC_RESET, marAddr);
		checkWord("fetch PC", `PC_RESET + 1, v);
		imm = $random(seed);
		imm[18] = 1'b1; // negative constant
		word = $random(seed);
		word.i.imm = imm;
		loadReg(3, word);
		nextCycle();
		busSrc.regOut[3] <= 1'b1;
		loadEn.irIn      <= 1'b1;
		nextCycle();
		busSrc.cOut <= 1'b1;
		sampleBus(v);
		checkWord("immediate", {13'h1fff, imm}, v);
	endtask

	task automatic conflictTest();
		logic [`WORD_WIDTH-1:0] a;
		logic [`WORD_WIDTH-1:0] b;
		logic [`WORD_WIDTH-1:0] v;
		a = $random(seed);
		b = $random(seed);
		loadReg(1, a);
		loadReg(2, b); // MDR is left holding b
		nextCycle();
		busSrc.regOut[1] <= 1'b1;
		busSrc.regOut[2] <= 1'b1;
		sampleBus(v);
		checkWord("R1 over R2", a, v);
		checkWord("two registers conflict", 1, busConflict);
		nextCycle();
		busSrc.mdrOut    <= 1'b1;
		busSrc.regOut[1] <= 1'b1;
		sampleBus(v);
		checkWord("MDR over R1", b, v);
		checkWord("MDR and R1 conflict", 1, busConflict);
		readReg(1, v);
		checkWord("single source conflict", 0, busConflict);
	endtask

	initial begin
		seed    = 32'hb086_ef92;
		rstN    = 1'b0;
		busSrc  = '0;
		loadEn  = '0;
		read    = 1'b0;
		memData = '0;
		aluOp   = add;
		repeat (3) @(posedge Clock);
		rstN <= 1'b1;
		resetTest();
		memTest(); // leaves a random word in MAR
		fetchTest(); // PC still at its reset value here
		aluTest();
		mulDivTest();
		conflictTest();
		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
+incdir+include
hw/datapath_pkg.sv
hw/busArbiter.sv
hw/registerFile.sv
hw/memInterface.sv
hw/fetchRegs.sv
hw/alu.sv
hw/cpuDatapath.sv
tests/datapath_tb.sv
